// File: source/dma_regs_pkg.sv
package dma_regs_pkg;

	////////////////////////////////////////////////////////////
	// Host register map
	////////////////////////////////////////////////////////////

	// Status on read, command on write
	localparam logic [1:0] REG_CTRL = 2'd0;
	// Source word address
	localparam logic [1:0] REG_SRC  = 2'd1;
	// Destination word address
	localparam logic [1:0] REG_DST  = 2'd2;
	// Word count, live remaining count while busy
	localparam logic [1:0] REG_LEN  = 2'd3;

	// "ABRT" in ASCII, written whole while busy
	localparam logic [31:0] ABORT_KEY = 32'h4142_5254;

	////////////////////////////////////////////////////////////
	// Control word
	////////////////////////////////////////////////////////////

	// Field layout, shared by status reads and idle command writes
	typedef struct packed {
		logic        go;        // Busy on read, go on write
		logic        err;       // Sticky error on read, clear on write
		logic        irq;       // Interrupt on read, clear on write
		logic [5:0]  rsvd_hi;
		logic        dst_fixed;
		logic [2:0]  rsvd_mid;
		logic        src_fixed;
		logic [16:0] rsvd_lo;
		logic        complete;  // Last copy ran to its final word
	} ctrl_fields_t;

	// Same word seen as fields or as one raw value for the abort key
	typedef union packed {
		ctrl_fields_t fields;
		logic [31:0]  raw;
	} ctrl_word_u;

endpackage

// File: source/dma_xfer_pkg.sv
package dma_xfer_pkg;

	////////////////////////////////////////////////////////////
	// Copy datapath widths
	////////////////////////////////////////////////////////////

	// Bus word and memory word
	// Host port byte enables are DATA_W/8 wide
	localparam int unsigned DATA_W = 32;

	// Word counter in the control and reader stages
	// Upper bytes of a length write are dropped
	localparam int unsigned LEN_W = 16;

endpackage

// File: source/dma_ctrl.sv
module dma_ctrl #(
	parameter int unsigned MEM_AW = 6
) (
	input  logic                              i_clk,
	input  logic                              i_reset,
	// Host register port
	input  logic                              i_stb,
	input  logic                              i_we,
	input  logic [1:0]                        i_addr,
	input  logic [dma_xfer_pkg::DATA_W-1:0]   i_data,
	input  logic [dma_xfer_pkg::DATA_W/8-1:0] i_sel,
	output logic                              o_ack,
	output logic [dma_xfer_pkg::DATA_W-1:0]   o_data,
	// Feedback from the copy stages
	input  logic                              i_busy,
	input  logic                              i_src_err,
	input  logic                              i_dst_err,
	input  logic                              i_done,
	input  logic [MEM_AW-1:0]                 i_current_src,
	input  logic [MEM_AW-1:0]                 i_current_dst,
	input  logic [dma_xfer_pkg::LEN_W-1:0]    i_remaining,
	// Transfer setup
	output logic                              o_request,
	output logic                              o_abort,
	output logic [MEM_AW-1:0]                 o_src_addr,
	output logic [MEM_AW-1:0]                 o_dst_addr,
	output logic [dma_xfer_pkg::LEN_W-1:0]    o_length,
	output logic                              o_src_fixed,
	output logic                              o_dst_fixed,
	output logic                              o_interrupt
);
	import dma_regs_pkg::*;
	import dma_xfer_pkg::*;

	ctrl_word_u        w_cmd;
	ctrl_word_u        w_status;
	logic [DATA_W-1:0] w_src_merge;
	logic [DATA_W-1:0] w_dst_merge;
	logic [DATA_W-1:0] w_len_merge;
	logic              w_wr;
	logic              w_ctrl_wr;
	logic              w_idle;
	logic              w_start;
	logic              r_err;
	logic              r_complete;
	logic              r_busy_q;

	// Byte lane merge of a write into an existing register
	function automatic logic [DATA_W-1:0] merge_bytes(
		input logic [DATA_W-1:0]   old_w,
		input logic [DATA_W-1:0]   new_w,
		input logic [DATA_W/8-1:0] sel
	);
		logic [DATA_W-1:0] res;
		res = old_w;
		for (int b = 0; b < DATA_W / 8; b++)
			if (sel[b])
				res[8*b +: 8] = new_w[8*b +: 8];
		return res;
	endfunction

	assign w_cmd     = i_data;
	assign w_wr      = i_stb && i_we;
	// Setup registers frozen from go until the stages drain
	assign w_idle    = !i_busy && !o_request;
	assign w_ctrl_wr = w_wr && (i_addr == REG_CTRL);

	// Go needs a length, and a pending error cleared in the same write
	assign w_start = w_ctrl_wr && w_idle && i_sel[3] && w_cmd.fields.go
		&& (o_length != '0) && (!r_err || w_cmd.fields.err);

	assign w_src_merge = merge_bytes(DATA_W'(o_src_addr), i_data, i_sel);
	assign w_dst_merge = merge_bytes(DATA_W'(o_dst_addr), i_data, i_sel);
	assign w_len_merge = merge_bytes(DATA_W'(o_length), i_data, i_sel);

	////////////////////////////////////////////////////////////
	// Host bus handshake and readback
	////////////////////////////////////////////////////////////

	// Never stalls, every strobe answered next cycle
	always_ff @(posedge i_clk)
	begin
		if (i_reset)
			o_ack <= 1'b0;
		else
			o_ack <= i_stb;
	end

	always_comb
	begin
		w_status = '0;
		w_status.fields.go        = i_busy;
		w_status.fields.err       = r_err;
		w_status.fields.irq       = o_interrupt;
		w_status.fields.dst_fixed = o_dst_fixed;
		w_status.fields.src_fixed = o_src_fixed;
		w_status.fields.complete  = r_complete;
	end

	// Live counters while busy, programmed values when idle
	always_ff @(posedge i_clk)
	begin
		if (i_stb)
		begin
			case (i_addr)
			REG_CTRL: o_data <= w_status.raw;
			REG_SRC:  o_data <= DATA_W'(i_busy ? i_current_src : o_src_addr);
			REG_DST:  o_data <= DATA_W'(i_busy ? i_current_dst : o_dst_addr);
			REG_LEN:  o_data <= DATA_W'(i_busy ? i_remaining : o_length);
			endcase
		end
	end

	////////////////////////////////////////////////////////////
	// Setup registers
	////////////////////////////////////////////////////////////

	always_ff @(posedge i_clk)
	begin
		if (i_reset)
		begin
			o_src_addr  <= '0;
			o_dst_addr  <= '0;
			o_length    <= '0;
			o_src_fixed <= 1'b0;
			o_dst_fixed <= 1'b0;
		end
		else if (w_wr && w_idle)
		begin
			case (i_addr)
			REG_CTRL:
			begin
				// Mode bits live in byte 2
				if (i_sel[2])
				begin
					o_src_fixed <= w_cmd.fields.src_fixed;
					o_dst_fixed <= w_cmd.fields.dst_fixed;
				end
			end
			REG_SRC: o_src_addr <= w_src_merge[MEM_AW-1:0];
			REG_DST: o_dst_addr <= w_dst_merge[MEM_AW-1:0];
			REG_LEN: o_length   <= w_len_merge[LEN_W-1:0];
			endcase
		end
	end

	////////////////////////////////////////////////////////////
	// Start, abort, error and interrupt
	////////////////////////////////////////////////////////////

	always_ff @(posedge i_clk)
	begin
		if (i_reset)
		begin
			o_request   <= 1'b0;
			o_abort     <= 1'b0;
			o_interrupt <= 1'b0;
			r_err       <= 1'b0;
			r_complete  <= 1'b0;
			r_busy_q    <= 1'b0;
		end
		else
		begin
			r_busy_q <= i_busy;
			// Abort is a single cycle pulse
			o_abort  <= 1'b0;
			// Request held until the reader has taken it
			if (i_busy)
				o_request <= 1'b0;
			// Stage errors only count during a transfer
			if (i_busy && (i_src_err || i_dst_err))
				r_err <= 1'b1;
			if (i_done)
				r_complete <= 1'b1;
			// Busy falling edge, both for completion and drain
			if (r_busy_q && !i_busy)
				o_interrupt <= 1'b1;

			if (w_ctrl_wr && !w_idle)
			begin
				// Running, only the full abort key is honoured
				if ((&i_sel) && (w_cmd.raw == ABORT_KEY))
				begin
					o_abort   <= 1'b1;
					o_request <= 1'b0;
				end
			end
			else if (w_ctrl_wr && i_sel[3])
			begin
				if (w_cmd.fields.err)
					r_err <= 1'b0;
				if (w_cmd.fields.irq)
					o_interrupt <= 1'b0;
				// New copy starts with a clean interrupt
				if (w_start)
				begin
					o_request   <= 1'b1;
					o_interrupt <= 1'b0;
					r_complete  <= 1'b0;
				end
			end
		end
	end

endmodule

// File: source/dma_reader.sv
module dma_reader #(
	parameter int unsigned MEM_AW = 6
) (
	input  logic                           i_clk,
	input  logic                           i_reset,
	input  logic                           i_request,
	input  logic                           i_abort,
	input  logic [MEM_AW-1:0]              i_src_addr,
	input  logic [dma_xfer_pkg::LEN_W-1:0] i_length,
	input  logic                           i_src_fixed,
	input  logic                           i_dst_err,
	output logic                           o_busy,
	output logic                           o_rd_valid,
	output logic [MEM_AW-1:0]              o_rd_addr,
	output logic                           o_word_valid,
	output logic                           o_last,
	output logic [MEM_AW-1:0]              o_current_src,
	output logic [dma_xfer_pkg::LEN_W-1:0] o_remaining,
	output logic                           o_src_err
);
	import dma_xfer_pkg::*;

	logic              r_active;
	logic [MEM_AW-1:0] r_addr;
	logic [LEN_W-1:0]  r_remaining;
	logic              r_fixed;
	logic              r_err;
	logic              r_last;
	// Bit 0 memory data stage, bit 1 writer store stage
	logic [1:0]        r_pipe;
	logic              w_load;
	logic              w_issue;
	logic              w_final;
	logic              w_wrap;

	assign w_load  = i_request && !o_busy;
	// Abort and writer error cut reads in the same cycle
	assign w_issue = r_active && !i_abort && !i_dst_err;
	assign w_final = (r_remaining == LEN_W'(1));
	// Top of memory reached with more words still to go
	assign w_wrap  = !r_fixed && (&r_addr) && !w_final;

	always_ff @(posedge i_clk)
	begin
		if (i_reset)
		begin
			r_active    <= 1'b0;
			r_remaining <= '0;
			r_err       <= 1'b0;
			r_last      <= 1'b0;
			r_pipe      <= '0;
		end
		else
		begin
			r_pipe <= {r_pipe[0], w_issue};
			r_last <= w_issue && w_final;
			if (w_load)
			begin
				r_active    <= 1'b1;
				r_remaining <= i_length;
				r_err       <= 1'b0;
			end
			else if (w_issue)
			begin
				r_remaining <= r_remaining - LEN_W'(1);
				if (w_final)
					r_active <= 1'b0;
				else if (w_wrap)
				begin
					r_active <= 1'b0;
					r_err    <= 1'b1;
				end
			end
			else
				r_active <= 1'b0;
		end
	end

	// Address and mode
	always_ff @(posedge i_clk)
	begin
		if (w_load)
		begin
			r_addr  <= i_src_addr;
			r_fixed <= i_src_fixed;
		end
		else if (w_issue && !r_fixed)
			r_addr <= r_addr + 1'b1;
	end

	// Busy covers the two words still in flight
	assign o_busy        = r_active || (|r_pipe);
	assign o_rd_valid    = w_issue;
	assign o_rd_addr     = r_addr;
	assign o_word_valid  = r_pipe[0];
	assign o_last        = r_last;
	assign o_current_src = r_addr;
	assign o_remaining   = r_remaining;
	assign o_src_err     = r_err;

endmodule

// File: source/dma_writer.sv
module dma_writer #(
	parameter int unsigned MEM_AW = 6
) (
	input  logic                            i_clk,
	input  logic                            i_reset,
	input  logic                            i_request,
	input  logic [MEM_AW-1:0]               i_dst_addr,
	input  logic                            i_dst_fixed,
	input  logic                            i_word_valid,
	input  logic                            i_last,
	input  logic [dma_xfer_pkg::DATA_W-1:0] i_rd_data,
	output logic                            o_wr_valid,
	output logic [MEM_AW-1:0]               o_wr_addr,
	output logic [dma_xfer_pkg::DATA_W-1:0] o_wr_data,
	output logic [MEM_AW-1:0]               o_current_dst,
	output logic                            o_dst_err,
	output logic                            o_done
);
	logic [MEM_AW-1:0] r_addr;
	logic              r_fixed;
	logic              r_err;
	logic              r_wr_last;
	logic              w_take;
	logic              w_wrap;

	// Words arriving after an overflow are dropped
	assign w_take = i_word_valid && !r_err;
	assign w_wrap = !r_fixed && (&r_addr) && !i_last;

	always_ff @(posedge i_clk)
	begin
		if (i_reset)
		begin
			o_wr_valid <= 1'b0;
			r_wr_last  <= 1'b0;
			r_err      <= 1'b0;
			o_done     <= 1'b0;
		end
		else
		begin
			o_wr_valid <= w_take;
			r_wr_last  <= w_take && i_last;
			// Done the cycle after the final store
			o_done     <= o_wr_valid && r_wr_last;
			if (i_request)
				r_err <= 1'b0;
			else if (w_take && w_wrap)
				r_err <= 1'b1;
		end
	end

	// Store address and data
	always_ff @(posedge i_clk)
	begin
		if (i_request)
		begin
			r_addr  <= i_dst_addr;
			r_fixed <= i_dst_fixed;
		end
		else if (w_take && !r_fixed)
			r_addr <= r_addr + 1'b1;
		o_wr_addr <= r_addr;
		o_wr_data <= i_rd_data;
	end

	assign o_current_dst = r_addr;
	assign o_dst_err     = r_err;

endmodule

// File: source/dma_memory.sv
module dma_memory #(
	parameter int unsigned MEM_AW = 6
) (
	input  logic                            i_clk,
	input  logic                            i_reset,
	// DMA read port, data one cycle later
	input  logic                            i_rd_valid,
	input  logic [MEM_AW-1:0]               i_rd_addr,
	output logic [dma_xfer_pkg::DATA_W-1:0] o_rd_data,
	// DMA write port
	input  logic                            i_wr_valid,
	input  logic [MEM_AW-1:0]               i_wr_addr,
	input  logic [dma_xfer_pkg::DATA_W-1:0] i_wr_data,
	// Host port
	input  logic                            i_mem_stb,
	input  logic                            i_mem_we,
	input  logic [MEM_AW-1:0]               i_mem_addr,
	input  logic [dma_xfer_pkg::DATA_W-1:0] i_mem_data,
	output logic                            o_mem_ack,
	output logic [dma_xfer_pkg::DATA_W-1:0] o_mem_data
);
	import dma_xfer_pkg::*;

	logic [DATA_W-1:0] r_mem [0:(1 << MEM_AW)-1];

	always_ff @(posedge i_clk)
	begin
		// DMA store wins a same cycle conflict
		if (i_wr_valid)
			r_mem[i_wr_addr] <= i_wr_data;
		else if (i_mem_stb && i_mem_we)
			r_mem[i_mem_addr] <= i_mem_data;
		if (i_rd_valid)
			o_rd_data <= r_mem[i_rd_addr];
		// Host read returns the word before any same cycle write
		if (i_mem_stb)
			o_mem_data <= r_mem[i_mem_addr];
	end

	always_ff @(posedge i_clk)
	begin
		if (i_reset)
			o_mem_ack <= 1'b0;
		else
			o_mem_ack <= i_mem_stb;
	end

endmodule

// File: source/dma_top.sv
module dma_top #(
	parameter int unsigned MEM_AW = 6
) (
	input  logic                              i_clk,
	input  logic                              i_reset,
	// Register port
	input  logic                              i_stb,
	input  logic                              i_we,
	input  logic [1:0]                        i_addr,
	input  logic [dma_xfer_pkg::DATA_W-1:0]   i_data,
	input  logic [dma_xfer_pkg::DATA_W/8-1:0] i_sel,
	output logic                              o_ack,
	output logic [dma_xfer_pkg::DATA_W-1:0]   o_data,
	// Memory port, idle use only
	input  logic                              i_mem_stb,
	input  logic                              i_mem_we,
	input  logic [MEM_AW-1:0]                 i_mem_addr,
	input  logic [dma_xfer_pkg::DATA_W-1:0]   i_mem_data,
	output logic                              o_mem_ack,
	output logic [dma_xfer_pkg::DATA_W-1:0]   o_mem_data,
	output logic                              o_interrupt
);
	import dma_xfer_pkg::*;

	// Control to stages
	logic              request, abort, src_fixed, dst_fixed;
	logic [MEM_AW-1:0] src_addr, dst_addr;
	logic [LEN_W-1:0]  length;
	// Stage feedback
	logic              busy, src_err, dst_err, done;
	logic [MEM_AW-1:0] current_src, current_dst;
	logic [LEN_W-1:0]  remaining;
	// Copy datapath
	logic              rd_valid, word_valid, last, wr_valid;
	logic [MEM_AW-1:0] rd_addr, wr_addr;
	logic [DATA_W-1:0] rd_data, wr_data;

	dma_ctrl #(.MEM_AW(MEM_AW)) u_ctrl (
		.i_clk, .i_reset, .i_stb, .i_we, .i_addr, .i_data, .i_sel,
		.o_ack, .o_data,
		.i_busy(busy), .i_src_err(src_err), .i_dst_err(dst_err), .i_done(done),
		.i_current_src(current_src), .i_current_dst(current_dst),
		.i_remaining(remaining),
		.o_request(request), .o_abort(abort), .o_src_addr(src_addr),
		.o_dst_addr(dst_addr), .o_length(length), .o_src_fixed(src_fixed),
		.o_dst_fixed(dst_fixed), .o_interrupt
	);

	dma_reader #(.MEM_AW(MEM_AW)) u_reader (
		.i_clk, .i_reset, .i_request(request), .i_abort(abort),
		.i_src_addr(src_addr), .i_length(length), .i_src_fixed(src_fixed),
		.i_dst_err(dst_err), .o_busy(busy), .o_rd_valid(rd_valid),
		.o_rd_addr(rd_addr), .o_word_valid(word_valid), .o_last(last),
		.o_current_src(current_src), .o_remaining(remaining), .o_src_err(src_err)
	);

	dma_writer #(.MEM_AW(MEM_AW)) u_writer (
		.i_clk, .i_reset, .i_request(request), .i_dst_addr(dst_addr),
		.i_dst_fixed(dst_fixed), .i_word_valid(word_valid), .i_last(last),
		.i_rd_data(rd_data), .o_wr_valid(wr_valid), .o_wr_addr(wr_addr),
		.o_wr_data(wr_data), .o_current_dst(current_dst), .o_dst_err(dst_err),
		.o_done(done)
	);

	dma_memory #(.MEM_AW(MEM_AW)) u_memory (
		.i_clk, .i_reset, .i_rd_valid(rd_valid), .i_rd_addr(rd_addr),
		.o_rd_data(rd_data), .i_wr_valid(wr_valid), .i_wr_addr(wr_addr),
		.i_wr_data(wr_data), .i_mem_stb, .i_mem_we, .i_mem_addr, .i_mem_data,
		.o_mem_ack, .o_mem_data
	);

endmodule

// File: tb/dma_asserts.sv
module dma_asserts #(
	parameter int unsigned MEM_AW = 6
) (
	input logic              i_clk,
	input logic              i_reset,
	input logic              i_stb,
	input logic              i_ack,
	input logic              i_busy,
	input logic              i_request,
	input logic              i_interrupt,
	input logic              i_wr_valid,
	input logic [MEM_AW-1:0] i_wr_addr
);
	timeunit 1ns;
	timeprecision 100ps;

	// Read by the testbench for its closing line
	int unsigned fail_count = 0;

	////////////////////////////////////////////////////////////
	// Host handshake and control timing
	////////////////////////////////////////////////////////////

	// Acknowledge mirrors the strobe one cycle late
	ack_follows_stb: assert property (@(posedge i_clk) disable iff (i_reset)
		i_ack == $past(i_stb))
	else
	begin
		fail_count++;
		$error("register acknowledge does not follow its strobe by one cycle");
	end

	// Interrupt edge only the cycle after busy fell
	irq_after_busy: assert property (@(posedge i_clk) disable iff (i_reset)
		$rose(i_interrupt) |-> (!$past(i_busy) && $past(i_busy, 2)))
	else
	begin
		fail_count++;
		$error("interrupt rose without busy falling one cycle before");
	end

	request_reset: assert property (@(posedge i_clk) i_reset |=> !i_request)
	else
	begin
		fail_count++;
		$error("request is high after reset");
	end

	// A store at the top word is never followed by one wrapped to word 0
	wr_addr_range: assert property (@(posedge i_clk) disable iff (i_reset)
		(i_wr_valid && $past(i_wr_valid) && (&$past(i_wr_addr))) |-> (&i_wr_addr))
	else
	begin
		fail_count++;
		$error("memory write address ran past the top of memory");
	end

endmodule

bind dma_top dma_asserts #(.MEM_AW(MEM_AW)) u_asserts (
	.i_clk,
	.i_reset,
	.i_stb,
	.i_ack(o_ack),
	.i_busy(busy),
	.i_request(request),
	.i_interrupt(o_interrupt),
	.i_wr_valid(wr_valid),
	.i_wr_addr(wr_addr)
);

// File: tb/dma_tb.sv
module dma_tb;
	timeunit 1ns;
	timeprecision 100ps;
	import dma_xfer_pkg::*;

	localparam int unsigned MEM_AW = 6;
	localparam int unsigned CLK_HALF = 5;
	localparam int unsigned RESET_CYCLES = 16;
	localparam int unsigned MAX_RECS = 128;
	// Per record allowance for bus accesses, and slack for the whole run
	localparam int unsigned ACCESS_CYCLES = 8;
	localparam int unsigned MARGIN_CYCLES = 100;
	localparam int unsigned ACK_LIMIT = 4;

	// Record kinds
	localparam logic [31:0] OP_REG_WR = 32'd1;
	localparam logic [31:0] OP_REG_RD = 32'd2;
	localparam logic [31:0] OP_MEM_WR = 32'd3;
	localparam logic [31:0] OP_MEM_RD = 32'd4;
	localparam logic [31:0] OP_WAIT_IRQ = 32'd5;

	logic                i_clk;
	logic                i_reset;
	logic                i_stb;
	logic                i_we;
	logic [1:0]          i_addr;
	logic [DATA_W-1:0]   i_data;
	logic [DATA_W/8-1:0] i_sel;
	logic                o_ack;
	logic [DATA_W-1:0]   o_data;
	logic                i_mem_stb;
	logic                i_mem_we;
	logic [MEM_AW-1:0]   i_mem_addr;
	logic [DATA_W-1:0]   i_mem_data;
	logic                o_mem_ack;
	logic [DATA_W-1:0]   o_mem_data;
	logic                o_interrupt;

	// Four words per record, zero op ends the list
	logic [31:0] stim [0:4*MAX_RECS-1];
	int unsigned mismatch_count = 0;
	int unsigned fault_count = 0;
	int unsigned cycle_limit = 0;
	int unsigned cycle_count = 0;

	dma_top #(.MEM_AW(MEM_AW)) dut (
		.i_clk, .i_reset, .i_stb, .i_we, .i_addr, .i_data, .i_sel, .o_ack, .o_data,
		.i_mem_stb, .i_mem_we, .i_mem_addr, .i_mem_data, .o_mem_ack, .o_mem_data,
		.o_interrupt
	);

	initial
	begin
		i_clk = 1'b0;
		forever #CLK_HALF i_clk = ~i_clk;
	end

	////////////////////////////////////////////////////////////
	// Bus access tasks, driven on the falling edge
	////////////////////////////////////////////////////////////

	task automatic await_ack(input logic mem_port);
		int unsigned n;
		n = 0;
		while (!(mem_port ? o_mem_ack : o_ack) && n < ACK_LIMIT)
		begin
			@(negedge i_clk);
			n++;
		end
		if (!(mem_port ? o_mem_ack : o_ack))
		begin
			fault_count++;
			$display("%s port gave no acknowledge by %0d ns",
				mem_port ? "memory" : "register", $time);
		end
	endtask

	// Data is taken at the falling edge after the acknowledge
	task automatic reg_access(
		input  logic                we,
		input  logic [1:0]          addr,
		input  logic [DATA_W-1:0]   data,
		input  logic [DATA_W/8-1:0] sel,
		output logic [DATA_W-1:0]   rdata
	);
		@(negedge i_clk);
		i_stb  = 1'b1;
		i_we   = we;
		i_addr = addr;
		i_data = data;
		i_sel  = sel;
		@(negedge i_clk);
		i_stb = 1'b0;
		i_we  = 1'b0;
		await_ack(1'b0);
		rdata = o_data;
	endtask

	task automatic mem_access(
		input  logic              we,
		input  logic [MEM_AW-1:0] addr,
		input  logic [DATA_W-1:0] data,
		output logic [DATA_W-1:0] rdata
	);
		@(negedge i_clk);
		i_mem_stb  = 1'b1;
		i_mem_we   = we;
		i_mem_addr = addr;
		i_mem_data = data;
		@(negedge i_clk);
		i_mem_stb = 1'b0;
		i_mem_we  = 1'b0;
		await_ack(1'b1);
		rdata = o_mem_data;
	endtask

	// Polls until the copy reports its end
	task automatic wait_interrupt(input int unsigned limit);
		int unsigned n;
		n = 0;
		while (!o_interrupt && n < limit)
		begin
			@(negedge i_clk);
			n++;
		end
		if (!o_interrupt)
		begin
			fault_count++;
			$display("timeout at %0d ns, no interrupt within %0d cycles", $time, limit);
		end
	endtask

	task automatic finish_run();
		int unsigned assert_fails;
		assert_fails = dut.u_asserts.fail_count;
		$display("error counts: %0d mismatches, %0d other failures, %0d assertion failures",
			mismatch_count, fault_count, assert_fails);
		if (mismatch_count == 0 && fault_count == 0 && assert_fails == 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	endtask

	////////////////////////////////////////////////////////////
	// Stimulus interpreter
	////////////////////////////////////////////////////////////

	initial
	begin
		int unsigned rec;
		logic [31:0] op;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] c;
		logic [DATA_W-1:0] rdata;
		i_reset    = 1'b1;
		i_stb      = 1'b0;
		i_we       = 1'b0;
		i_addr     = '0;
		i_data     = '0;
		i_sel      = '0;
		i_mem_stb  = 1'b0;
		i_mem_we   = 1'b0;
		i_mem_addr = '0;
		i_mem_data = '0;
		for (int k = 0; k < 4 * MAX_RECS; k++)
			stim[k] = '0;
		$readmemh("tb/dma_stim.txt", stim);

		// Run limit from what every record may take
		rec = 0;
		cycle_limit = RESET_CYCLES + MARGIN_CYCLES;
		while (rec < MAX_RECS && stim[4*rec] != '0)
		begin
			cycle_limit += (stim[4*rec] == OP_WAIT_IRQ) ? stim[4*rec+1] : ACCESS_CYCLES;
			rec++;
		end

		repeat (RESET_CYCLES) @(negedge i_clk);
		i_reset = 1'b0;

		rec = 0;
		while (rec < MAX_RECS && stim[4*rec] != '0)
		begin
			op = stim[4*rec];
			a  = stim[4*rec+1];
			b  = stim[4*rec+2];
			c  = stim[4*rec+3];
			case (op)
			OP_REG_WR: reg_access(1'b1, a[1:0], b, c[3:0], rdata);
			OP_REG_RD:
			begin
				reg_access(1'b0, a[1:0], '0, 4'hf, rdata);
				if (rdata !== b)
				begin
					mismatch_count++;
					$display("mismatch at %0d ns: o_data of register %0d is %h, expected %h",
						$time, a[1:0], rdata, b);
				end
			end
			OP_MEM_WR: mem_access(1'b1, a[MEM_AW-1:0], b, rdata);
			OP_MEM_RD:
			begin
				mem_access(1'b0, a[MEM_AW-1:0], '0, rdata);
				if (rdata !== b)
				begin
					mismatch_count++;
					$display("mismatch at %0d ns: o_mem_data of word %0d is %h, expected %h",
						$time, a[MEM_AW-1:0], rdata, b);
				end
			end
			OP_WAIT_IRQ: wait_interrupt(a);
			default:
			begin
				fault_count++;
				$display("stimulus record %0d has an unknown kind %0d", rec, op);
			end
			endcase
			rec++;
		end
		finish_run();
	end

	// Watchdog over the whole run
	initial
	begin
		wait (cycle_limit != 0);
		while (cycle_count < cycle_limit)
		begin
			@(posedge i_clk);
			cycle_count++;
		end
		fault_count++;
		$display("run stopped after %0d cycles before the stimulus ended", cycle_count);
		finish_run();
	end

endmodule

// File: tb/dma_stim.txt
// Columns: op a b c as hex words, one record of four words per line, unused columns 0
// op 1 reg write a=reg b=data c=sel, op 2 reg read a=reg b=expected
// op 3 mem write a=word b=data, op 4 mem read a=word b=expected, op 5 irq wait a=cycles

// Reset values
2 0 00000000 0
2 1 00000000 0
2 2 00000000 0
2 3 00000000 0
// Byte lanes, length keeps 16 bits and source keeps 6
1 3 12345678 f
1 3 AABBCCDD 2
1 3 00FF0000 4
2 3 0000CC78 0
1 1 FFFFFFA5 1
1 1 0000AB00 2
2 1 00000025 0

// Source words 0 to 7
3 0 3C2A9F10 0
3 1 7E51B4C3 0
3 2 0D93E6A7 0
3 3 58F04C1B 0
3 4 C61D7A92 0
3 5 2B8E35F4 0
3 6 94A7D058 0
3 7 E3660BCD 0

// Incrementing copy 0..7 to 10..17
1 1 00000000 f
1 2 00000010 f
1 3 00000008 f
1 0 80000000 f
5 28 00000000 0
4 10 3C2A9F10 0
4 11 7E51B4C3 0
4 12 0D93E6A7 0
4 13 58F04C1B 0
4 14 C61D7A92 0
4 15 2B8E35F4 0
4 16 94A7D058 0
4 17 E3660BCD 0
2 0 20000001 0

// Fixed source word 3 into 20..23
1 1 00000003 f
1 2 00000020 f
1 3 00000004 f
1 0 80040000 f
5 28 00000000 0
4 20 58F04C1B 0
4 23 58F04C1B 0
// Fixed destination 28 keeps the last of words 4..7
1 1 00000004 f
1 2 00000028 f
1 0 80400000 f
5 28 00000000 0
4 28 E3660BCD 0

// Abort a 30 word copy right after go, marker at the far end
3 3D DEADBEEF 0
1 1 00000005 f
1 2 00000020 f
1 3 0000001E f
1 0 80040000 f
1 0 41425254 f
5 28 00000000 0
2 3 0000001E 0
2 0 20040000 0
4 20 2B8E35F4 0
4 21 58F04C1B 0
4 3D DEADBEEF 0

// Destination overflow at the top of memory
1 1 00000000 f
1 2 0000003C f
1 3 00000008 f
1 0 80000000 f
5 28 00000000 0
2 0 60000000 0
4 3F 58F04C1B 0
// Go alone is refused while the error is pending
1 0 80000000 f
2 0 60000000 0
// Go with error clear runs to completion
1 2 00000030 f
1 0 C0000000 f
5 28 00000000 0
2 0 20000001 0
4 30 3C2A9F10 0
4 37 E3660BCD 0

// File: list.f
source/dma_regs_pkg.sv
source/dma_xfer_pkg.sv
source/dma_ctrl.sv
source/dma_reader.sv
source/dma_writer.sv
source/dma_memory.sv
source/dma_top.sv
tb/dma_asserts.sv
tb/dma_tb.sv

// File: run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/100ps \
	--top-module dma_tb -f list.f -o sim_dma

output=$(./obj_dir/sim_dma +verilator+error+limit+1000)
echo "$output"

if grep -qx "Testbench passed" <<< "$output"; then
	exit 0
else
	exit 1
fi
